// ==== source/bicubic_pkg.sv ====
`default_nettype none

package bicubic_pkg;

    localparam int FRAC_BITS    = 8;    // Fraction bits of a position
    localparam int WEIGHT_ONE   = 256;  // Unity gain that the weights sum to
    localparam int WEIGHT_SHIFT = 17;   // Drops the 2^24 f^3 scale and the halving to leave 1/256
    localparam int ROUND_BIAS   = 128;  // Half of one unit before the shift
    localparam int PIXEL_MAX    = 255;

    typedef logic [7:0]          pixel_t;
    typedef logic [13:0]         img_addr_t;
    typedef logic [9:0]          res_addr_t;  // Up to 32x32 results
    typedef logic [5:0]          coord_t;
    typedef logic [15:0]         pos_t;       // 8.8 fixed point
    typedef logic [7:0]          frac_t;
    typedef logic signed [10:0]  weight_t;

    typedef struct packed {
        logic [6:0] v0;
        logic [6:0] h0;
        logic [4:0] sw;
        logic [4:0] sh;
        coord_t     tw;
        coord_t     th;
    } job_cfg_t;

    // Sampled position split into integer and fraction parts
    typedef struct packed {
        logic [7:0] ix;
        logic [7:0] iy;
        frac_t      fx;
        frac_t      fy;
    } sample_pos_t;

    typedef struct packed {
        pixel_t [3:0][3:0] px;  // px[row][col], row-major
    } pixel_window_t;

    typedef struct packed {
        weight_t w0;
        weight_t w1;
        weight_t w2;
        weight_t w3;
    } weight_set_t;

    typedef struct packed {
        logic      en;
        img_addr_t addr;
    } src_rd_t;

    typedef struct packed {
        logic      en;
        res_addr_t addr;
        pixel_t    data;
    } res_wr_t;

endpackage

`default_nettype wire

// ==== source/cubic_weights.sv ====
`default_nettype none

module cubic_weights (
    input  wire                        CLK,
    input  wire                        RST,
    input  wire bicubic_pkg::frac_t    frac,
    output bicubic_pkg::weight_set_t   weights
);

    logic signed [27:0]   f;
    logic signed [27:0]   f2;
    logic signed [27:0]   f3;
    logic signed [27:0]   n0;
    logic signed [27:0]   n2;
    logic signed [27:0]   n3;
    bicubic_pkg::weight_t w0;
    bicubic_pkg::weight_t w1;
    bicubic_pkg::weight_t w2;
    bicubic_pkg::weight_t w3;

    assign f  = 28'(frac);
    assign f2 = f * f;     // Shared by all three polynomials
    assign f3 = f2 * f;

    // Numerators over 2^24 before the halving and the 1/256 scale
    assign n0 = -f3 + (f2 <<< 9) - (f <<< 16);
    assign n2 = -(f3 + (f3 <<< 1)) + (f2 <<< 10) + (f <<< 16);
    assign n3 = f3 - (f2 <<< 8);

    // Upper bits are the floor of the quotient
    assign w0 = n0[bicubic_pkg::WEIGHT_SHIFT +: $bits(bicubic_pkg::weight_t)];
    assign w2 = n2[bicubic_pkg::WEIGHT_SHIFT +: $bits(bicubic_pkg::weight_t)];
    assign w3 = n3[bicubic_pkg::WEIGHT_SHIFT +: $bits(bicubic_pkg::weight_t)];
    assign w1 = bicubic_pkg::weight_t'(bicubic_pkg::WEIGHT_ONE) - w0 - w2 - w3;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            weights <= '0;
        end else begin
            weights <= '{w0: w0, w1: w1, w2: w2, w3: w3};
        end
    end

endmodule

`default_nettype wire

// ==== source/interp_engine.sv ====
`default_nettype none

module interp_engine (
    input  wire                              CLK,
    input  wire                              RST,
    input  wire                              calc_start,
    input  wire bicubic_pkg::sample_pos_t    sample_pos,
    input  wire bicubic_pkg::pixel_window_t  window,
    output bicubic_pkg::pixel_t              result,
    output logic                             result_valid
);

    bicubic_pkg::weight_set_t   wx;
    bicubic_pkg::weight_set_t   wy;
    bicubic_pkg::pixel_t [3:0]  row_res;
    logic [2:0]                 phase;    // 1..4 rows, 5 column
    logic [1:0]                 row_sel;

    // One 4-tap pass with rounding and clamping
    function automatic bicubic_pkg::pixel_t filter4(
        input bicubic_pkg::weight_set_t w,
        input bicubic_pkg::pixel_t [3:0] s
    );
        logic signed [21:0] acc;
        acc = w.w0 * $signed({1'b0, s[0]})
            + w.w1 * $signed({1'b0, s[1]})
            + w.w2 * $signed({1'b0, s[2]})
            + w.w3 * $signed({1'b0, s[3]});
        acc = (acc + 22'(bicubic_pkg::ROUND_BIAS)) >>> bicubic_pkg::FRAC_BITS;
        if (acc < 0) begin
            filter4 = '0;
        end else if (acc > 22'(bicubic_pkg::PIXEL_MAX)) begin
            filter4 = 8'hff;
        end else begin
            filter4 = acc[7:0];
        end
    endfunction

    cubic_weights u_weights_x (
        .CLK     (CLK),
        .RST     (RST),
        .frac    (sample_pos.fx),
        .weights (wx)
    );

    cubic_weights u_weights_y (
        .CLK     (CLK),
        .RST     (RST),
        .frac    (sample_pos.fy),
        .weights (wy)
    );

    assign row_sel = 2'(phase - 3'd1);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            phase        <= '0;
            result_valid <= 1'b0;
        end else begin
            if (calc_start) begin
                phase <= 3'd1;  // Weights settle on this edge
            end else if (phase == 3'd5) begin
                phase <= '0;
            end else if (phase != '0) begin
                phase <= phase + 3'd1;
            end
            result_valid <= (phase == 3'd5);
        end
    end

    always_ff @(posedge CLK) begin
        if (phase inside {[3'd1:3'd4]}) begin
            row_res[row_sel] <= filter4(wx, window.px[row_sel]);  // Horizontal pass
        end else if (phase == 3'd5) begin
            result <= filter4(wy, row_res);   // Vertical pass
        end
    end

endmodule

`default_nettype wire

// ==== source/window_fetch.sv ====
`default_nettype none

module window_fetch #(
    parameter int unsigned SRC_WIDTH  = 100,
    parameter int unsigned SRC_HEIGHT = 100
) (
    input  wire                            CLK,
    input  wire                            RST,
    input  wire                            fetch_start,
    input  wire bicubic_pkg::sample_pos_t  sample_pos,
    input  wire bicubic_pkg::pixel_t       src_data,
    output bicubic_pkg::src_rd_t           src_rd,
    output bicubic_pkg::pixel_window_t     window,
    output logic                           window_valid
);

    logic                   rd_active;
    logic [3:0]             rd_idx;      // {row, col} within the 4x4
    logic                   cap_active;
    logic [3:0]             cap_idx;
    logic [8:0]             rd_row;
    logic [8:0]             rd_col;
    bicubic_pkg::img_addr_t row_base;

    // Neighbourhood spans iy-1..iy+2 and ix-1..ix+2
    assign rd_row = 9'(sample_pos.iy) + 9'(rd_idx[3:2]) - 9'd1;
    assign rd_col = 9'(sample_pos.ix) + 9'(rd_idx[1:0]) - 9'd1;

    // Row times image width as a sum of shifted rows
    always_comb begin
        row_base = '0;
        for (int b = 0; b < $bits(bicubic_pkg::img_addr_t); b++) begin
            if (SRC_WIDTH[b]) begin
                row_base = row_base + (bicubic_pkg::img_addr_t'(rd_row) << b);
            end
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rd_active  <= 1'b0;
            rd_idx     <= '0;
            cap_active <= 1'b0;
            cap_idx    <= '0;
        end else begin
            if (fetch_start) begin
                rd_active <= 1'b1;
                rd_idx    <= '0;
            end else if (rd_active) begin
                rd_idx <= rd_idx + 4'd1;
                if (rd_idx == 4'd15) rd_active <= 1'b0;
            end
            cap_active <= rd_active;  // Memory answers one cycle later
            cap_idx    <= rd_idx;
        end
    end

    always_ff @(posedge CLK) begin
        if (cap_active) window.px[cap_idx[3:2]][cap_idx[1:0]] <= src_data;
    end

    assign src_rd       = '{en: rd_active, addr: row_base + bicubic_pkg::img_addr_t'(rd_col)};
    assign window_valid = cap_active && (cap_idx == 4'd15);  // Last pixel lands on this edge

    // Job window must keep the whole neighbourhood inside the image
    a_in_image: assert property (@(posedge CLK) disable iff (RST)
        src_rd.en |-> (rd_row < SRC_HEIGHT) && (rd_col < SRC_WIDTH)
                      && (src_rd.addr < SRC_WIDTH * SRC_HEIGHT))
        else $error("Source read outside the image at row %0d col %0d", rd_row, rd_col);

endmodule

`default_nettype wire

// ==== source/target_stepper.sv ====
`default_nettype none

module target_stepper (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire bicubic_pkg::job_cfg_t   cfg,
    input  wire                          cfg_load,
    input  wire                          advance,
    output bicubic_pkg::sample_pos_t     sample_pos,
    output bicubic_pkg::res_addr_t       res_addr,
    output logic                         last_pixel
);

    bicubic_pkg::coord_t tx;
    bicubic_pkg::coord_t ty;
    bicubic_pkg::coord_t tw_q;
    bicubic_pkg::coord_t th_q;
    logic [6:0]          h0_q;
    bicubic_pkg::pos_t   step_x;
    bicubic_pkg::pos_t   step_y;
    bicubic_pkg::pos_t   pos_x;
    bicubic_pkg::pos_t   pos_y;
    logic                row_end;

    // Only 8, 16 and 32 are legal target sizes
    function automatic logic [2:0] size_log2(input bicubic_pkg::coord_t size);
        case (size)
            6'd16:   size_log2 = 3'd4;
            6'd32:   size_log2 = 3'd5;
            default: size_log2 = 3'd3;
        endcase
    endfunction

    assign row_end = (tx == tw_q - 6'd1);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            tx   <= '0;
            ty   <= '0;
            tw_q <= '0;
            th_q <= '0;
        end else if (cfg_load) begin
            tx   <= '0;
            ty   <= '0;
            tw_q <= cfg.tw;
            th_q <= cfg.th;
        end else if (advance) begin
            if (row_end) begin
                tx <= '0;
                ty <= ty + 6'd1;
            end else begin
                tx <= tx + 6'd1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cfg_load) begin
            h0_q   <= cfg.h0;
            // Source span in 1/256 divided by the target size
            step_x <= (bicubic_pkg::pos_t'(cfg.sw) << bicubic_pkg::FRAC_BITS) >> size_log2(cfg.tw);
            step_y <= (bicubic_pkg::pos_t'(cfg.sh) << bicubic_pkg::FRAC_BITS) >> size_log2(cfg.th);
            pos_x  <= bicubic_pkg::pos_t'(cfg.h0) << bicubic_pkg::FRAC_BITS;
            pos_y  <= bicubic_pkg::pos_t'(cfg.v0) << bicubic_pkg::FRAC_BITS;
        end else if (advance) begin
            if (row_end) begin
                pos_x <= bicubic_pkg::pos_t'(h0_q) << bicubic_pkg::FRAC_BITS;  // Back to h0
                pos_y <= pos_y + step_y;
            end else begin
                pos_x <= pos_x + step_x;
            end
        end
    end

    assign sample_pos = '{ix: pos_x[15:8], iy: pos_y[15:8], fx: pos_x[7:0], fy: pos_y[7:0]};
    assign res_addr   = (bicubic_pkg::res_addr_t'(ty) << size_log2(tw_q))
                        + bicubic_pkg::res_addr_t'(tx);
    assign last_pixel = row_end && (ty == th_q - 6'd1);

    a_pow2_size: assert property (@(posedge CLK) disable iff (RST)
        cfg_load |=> (tw_q inside {6'd8, 6'd16, 6'd32}) && (th_q inside {6'd8, 6'd16, 6'd32}))
        else $error("Target size is not 8, 16 or 32");

endmodule

`default_nettype wire

// ==== source/scale_sequencer.sv ====
`default_nettype none

module scale_sequencer (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          window_valid,
    input  wire                          result_valid,
    input  wire                          last_pixel,
    input  wire bicubic_pkg::res_addr_t  res_addr,
    input  wire bicubic_pkg::pixel_t     result,
    output logic                         cfg_load,
    output logic                         fetch_start,
    output logic                         calc_start,
    output logic                         advance,
    output bicubic_pkg::res_wr_t         res_wr,
    output logic                         done
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        FETCH,
        CALC,
        WRITE,
        STEP,
        FINISH
    } state_t;

    state_t state;
    state_t state_nx;

    logic                   wr_en;
    bicubic_pkg::res_addr_t wr_addr;
    bicubic_pkg::pixel_t    wr_data;
    logic                   wr_take;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    state_nx = LOAD;
            LOAD:    state_nx = FETCH;
            FETCH:   if (window_valid) state_nx = CALC;
            CALC:    if (result_valid) state_nx = WRITE;
            WRITE:   state_nx = last_pixel ? FINISH : STEP;
            STEP:    state_nx = FETCH;
            FINISH:  state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    assign wr_take = (state == CALC) && result_valid;  // Result held this cycle

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state       <= IDLE;
            fetch_start <= 1'b0;
            calc_start  <= 1'b0;
            wr_en       <= 1'b0;
        end else begin
            state       <= state_nx;
            // Strobe on the first cycle of each wait state
            fetch_start <= (state_nx == FETCH) && (state != FETCH);
            calc_start  <= (state_nx == CALC) && (state != CALC);
            wr_en       <= wr_take;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_take) begin
            wr_addr <= res_addr;
            wr_data <= result;
        end
    end

    assign cfg_load = (state == LOAD);
    assign advance  = (state == STEP);   // Position moves once the write is out
    assign done     = (state == FINISH);
    assign res_wr   = '{en: wr_en, addr: wr_addr, data: wr_data};

    // A new fetch or filter pass never overlaps the pending write
    a_no_overlap: assert property (@(posedge CLK) disable iff (RST)
        res_wr.en |-> !(fetch_start || calc_start))
        else $error("fetch_start or calc_start coincides with res_wr.en");

endmodule

`default_nettype wire

// ==== source/bicubic_top.sv ====
`default_nettype none

module bicubic_top #(
    parameter int unsigned SRC_WIDTH  = 100,
    parameter int unsigned SRC_HEIGHT = 100
) (
    input  wire                         CLK,
    input  wire                         RST,
    input  wire bicubic_pkg::job_cfg_t  cfg,
    output bicubic_pkg::src_rd_t        src_rd,
    input  wire bicubic_pkg::pixel_t    src_data,
    output bicubic_pkg::res_wr_t        res_wr,
    output logic                        done
);

    // Sequencer strobes
    logic cfg_load;
    logic fetch_start;
    logic calc_start;
    logic advance;

    // Status back to the sequencer
    logic window_valid;
    logic result_valid;
    logic last_pixel;

    // Datapath
    bicubic_pkg::sample_pos_t   sample_pos;
    bicubic_pkg::res_addr_t     res_addr;
    bicubic_pkg::pixel_window_t window;
    bicubic_pkg::pixel_t        result;

    scale_sequencer u_sequencer (
        .CLK          (CLK),
        .RST          (RST),
        .window_valid (window_valid),
        .result_valid (result_valid),
        .last_pixel   (last_pixel),
        .res_addr     (res_addr),
        .result       (result),
        .cfg_load     (cfg_load),
        .fetch_start  (fetch_start),
        .calc_start   (calc_start),
        .advance      (advance),
        .res_wr       (res_wr),
        .done         (done)
    );

    target_stepper u_stepper (
        .CLK        (CLK),
        .RST        (RST),
        .cfg        (cfg),
        .cfg_load   (cfg_load),
        .advance    (advance),
        .sample_pos (sample_pos),
        .res_addr   (res_addr),
        .last_pixel (last_pixel)
    );

    window_fetch #(
        .SRC_WIDTH  (SRC_WIDTH),
        .SRC_HEIGHT (SRC_HEIGHT)
    ) u_fetch (
        .CLK          (CLK),
        .RST          (RST),
        .fetch_start  (fetch_start),
        .sample_pos   (sample_pos),
        .src_data     (src_data),
        .src_rd       (src_rd),
        .window       (window),
        .window_valid (window_valid)
    );

    interp_engine u_engine (
        .CLK          (CLK),
        .RST          (RST),
        .calc_start   (calc_start),
        .sample_pos   (sample_pos),
        .window       (window),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== verification/bicubic_checker.sv ====
`default_nettype none

module bicubic_checker #(
    parameter int IMG_W = 100,
    parameter int IMG_H = 100
) (
    input  wire                        CLK,
    input  wire                        RST,
    input  wire bicubic_pkg::job_cfg_t cfg,
    input  wire [1:0]                  job_kind,
    input  wire [10:0]                 n_expect,
    input  wire bicubic_pkg::src_rd_t  src_rd,
    input  wire bicubic_pkg::res_wr_t  res_wr,
    input  wire                        done,
    input  wire bicubic_pkg::pixel_t   src_img [0:IMG_W*IMG_H-1],
    output int                         pass_count,
    output int                         fail_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] KIND_FLAT   = 2'd0;
    localparam logic [1:0] KIND_WHOLE  = 2'd1;
    localparam logic [1:0] KIND_RANDOM = 2'd2;
    localparam logic [1:0] KIND_EDGE   = 2'd3;

    int   res_hits [0:1023];  // Writes seen per result address
    int   n_pass       = 0;
    int   n_fail       = 0;
    int   job_idx      = 0;
    int   job_errs     = 0;
    int   job_writes   = 0;
    int   job_clamps   = 0;
    int   reset_cycles = 0;
    logic done_q       = 1'b0;

    assign pass_count = n_pass;
    assign fail_count = n_fail;

    // Rounds toward negative infinity
    function automatic int floor_div(input int n, input int d);
        int q;
        q = n / d;
        if ((n % d != 0) && (n < 0)) q = q - 1;
        return q;
    endfunction

    // Cubic convolution weights with a = -1/2 in units of 1/256
    function automatic int weight_of(input int f, input int k);
        int f2;
        int f3;
        int w0;
        int w2;
        int w3;
        f2 = f * f;
        f3 = f2 * f;
        w0 = floor_div(-f3 + 512 * f2 - 65536 * f, 131072);
        w2 = floor_div(-3 * f3 + 1024 * f2 + 65536 * f, 131072);
        w3 = floor_div(f3 - 256 * f2, 131072);
        case (k)
            0:       return w0;
            1:       return 256 - w0 - w2 - w3;  // Unity gain
            2:       return w2;
            default: return w3;
        endcase
    endfunction

    // Rounded 4-tap result before clamping
    function automatic int filter_raw(input int f, input int s0, input int s1,
                                      input int s2, input int s3);
        int acc;
        acc = weight_of(f, 0) * s0 + weight_of(f, 1) * s1
            + weight_of(f, 2) * s2 + weight_of(f, 3) * s3;
        return floor_div(acc + 128, 256);
    endfunction

    function automatic int saturate(input int v);
        if (v < 0) return 0;
        if (v > 255) return 255;
        return v;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_FLAT:   return "flat";
            KIND_WHOLE:  return "whole-step";
            KIND_RANDOM: return "random";
            default:     return "edge";
        endcase
    endfunction

    task automatic expect_low(input string name, input logic v);
        if (v !== 1'b0) begin
            $display("FAIL %s expected 0x0 got 0x%0h", name, v);
            job_errs++;
        end
    endtask

    task automatic report_test(input string what);
        if (job_errs == 0) begin
            $display("PASS %s", what);
            n_pass++;
        end else begin
            $display("FAIL %s with %0d errors", what, job_errs);
            n_fail++;
        end
        job_errs = 0;
    endtask

    task automatic clear_results();
        int a;
        for (a = 0; a < 1024; a++) res_hits[a] = 0;
        job_writes = 0;
        job_clamps = 0;
    endtask

    task automatic check_write(input bicubic_pkg::res_addr_t a, input bicubic_pkg::pixel_t got);
        int tw;
        int th;
        int px;
        int py;
        int ix;
        int iy;
        int base;
        int v;
        int r;
        int exp_px;
        int row [4];
        tw = int'(cfg.tw);
        th = int'(cfg.th);
        if (int'(a) >= tw * th) begin
            $display("Write to address 0x%0h lies outside the %0dx%0d target", a, tw, th);
            job_errs++;
        end else begin
            res_hits[a] = res_hits[a] + 1;
            job_writes++;
            // Source position in 1/256 pixel
            px = int'(cfg.h0) * 256 + (int'(a) % tw) * ((int'(cfg.sw) * 256) / tw);
            py = int'(cfg.v0) * 256 + (int'(a) / tw) * ((int'(cfg.sh) * 256) / th);
            ix = px / 256;
            iy = py / 256;
            for (r = 0; r < 4; r++) begin
                base = (iy - 1 + r) * IMG_W + ix - 1;
                v = filter_raw(px % 256, int'(src_img[base]), int'(src_img[base + 1]),
                               int'(src_img[base + 2]), int'(src_img[base + 3]));
                if (v != saturate(v)) job_clamps++;
                row[r] = saturate(v);
            end
            v = filter_raw(py % 256, row[0], row[1], row[2], row[3]);  // Column pass
            if (v != saturate(v)) job_clamps++;
            exp_px = saturate(v);
            if (got !== 8'(exp_px)) begin
                $display("FAIL res_wr.data addr 0x%03h expected 0x%02h got 0x%02h",
                         a, exp_px, got);
                job_errs++;
            end
            if ((job_kind == KIND_FLAT || job_kind == KIND_WHOLE)
                    && got !== src_img[iy * IMG_W + ix]) begin
                $display("FAIL res_wr.data addr 0x%03h expected 0x%02h got 0x%02h",
                         a, src_img[iy * IMG_W + ix], got);
                job_errs++;
            end
        end
    endtask

    task automatic finish_job();
        int a;
        int n;
        int missing;
        int dup;
        n = int'(cfg.tw) * int'(cfg.th);
        missing = 0;
        dup = 0;
        for (a = 0; a < n; a++) begin
            if (res_hits[a] == 0) missing++;
            else if (res_hits[a] > 1) dup++;
        end
        if (job_writes != int'(n_expect)) begin
            $display("Job %0d wrote %0d pixels instead of %0d", job_idx, job_writes, n_expect);
            job_errs++;
        end
        if (missing != 0 || dup != 0) begin
            $display("Job %0d left %0d addresses unwritten and wrote %0d more than once",
                     job_idx, missing, dup);
            job_errs++;
        end
        if (job_kind == KIND_EDGE && job_clamps == 0) begin
            $display("Job %0d near the 0/255 edge never clamped a value", job_idx);
            job_errs++;
        end
        report_test($sformatf("job %0d %s %0dx%0d with %0d writes", job_idx,
                              kind_name(job_kind), cfg.tw, cfg.th, job_writes));
        clear_results();
        job_idx++;
    endtask

    always @(negedge CLK) begin
        if (RST) begin
            clear_results();
            reset_cycles = 0;
            expect_low("done", done);
            expect_low("res_wr.en", res_wr.en);
            expect_low("src_rd.en", src_rd.en);
        end else begin
            if (reset_cycles < 2) begin  // Until cfg is first sampled
                expect_low("done", done);
                expect_low("res_wr.en", res_wr.en);
                expect_low("src_rd.en", src_rd.en);
                reset_cycles++;
                if (reset_cycles == 2) report_test("reset leaves all strobes low");
            end
            if (res_wr.en) check_write(res_wr.addr, res_wr.data);
            if (done && done_q) begin
                $display("done stayed high for more than one cycle");
                job_errs++;
            end else if (done) begin
                finish_job();
            end
            done_q = done;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_bicubic.sv ====
`default_nettype none

module tb_bicubic;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          IMG_W      = 100;
    localparam int          IMG_H      = 100;
    localparam int          NUM_JOBS   = 5;
    localparam logic [31:0] SEED       = 32'hc978;
    localparam logic [7:0]  FLAT_VALUE = 8'h6b;

    localparam logic [1:0] KIND_FLAT   = 2'd0;
    localparam logic [1:0] KIND_WHOLE  = 2'd1;
    localparam logic [1:0] KIND_RANDOM = 2'd2;
    localparam logic [1:0] KIND_EDGE   = 2'd3;

    typedef struct packed {
        bicubic_pkg::job_cfg_t cfg;
        logic [10:0]           n_writes;
        logic [1:0]            kind;
    } job_t;

    // cfg is v0, h0, sw, sh, tw, th, then the write count and the behavior
    job_t jobs [NUM_JOBS] = '{
        '{'{7'd5,  7'd65, 5'd20, 5'd20, 6'd16, 6'd8},  11'd128,  KIND_FLAT},
        '{'{7'd42, 7'd42, 5'd16, 5'd8,  6'd8,  6'd8},  11'd64,   KIND_WHOLE},
        '{'{7'd10, 7'd10, 5'd24, 5'd28, 6'd32, 6'd32}, 11'd1024, KIND_RANDOM},
        '{'{7'd55, 7'd5,  5'd30, 5'd20, 6'd16, 6'd16}, 11'd256,  KIND_EDGE},
        '{'{7'd60, 7'd60, 5'd12, 5'd31, 6'd8,  6'd32}, 11'd256,  KIND_RANDOM}
    };

    logic                      CLK      = 1'b0;
    logic                      RST      = 1'b1;
    bicubic_pkg::job_cfg_t     cfg;
    bicubic_pkg::src_rd_t      src_rd;
    bicubic_pkg::pixel_t       src_data = '0;
    bicubic_pkg::res_wr_t      res_wr;
    logic                      done;
    logic [1:0]                job_kind;
    logic [10:0]               n_expect;
    int                        pass_count;
    int                        fail_count;
    bicubic_pkg::pixel_t       src_mem [0:IMG_W*IMG_H-1];
    bicubic_pkg::img_addr_t    rd_addr;

    always #2 CLK = ~CLK;

    bicubic_top #(
        .SRC_WIDTH  (IMG_W),
        .SRC_HEIGHT (IMG_H)
    ) UUT (
        .CLK      (CLK),
        .RST      (RST),
        .cfg      (cfg),
        .src_rd   (src_rd),
        .src_data (src_data),
        .res_wr   (res_wr),
        .done     (done)
    );

    bicubic_checker #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_checker (
        .CLK        (CLK),
        .RST        (RST),
        .cfg        (cfg),
        .job_kind   (job_kind),
        .n_expect   (n_expect),
        .src_rd     (src_rd),
        .res_wr     (res_wr),
        .done       (done),
        .src_img    (src_mem),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    // Source image answers one cycle after the read
    always @(posedge CLK) begin
        if (src_rd.en) begin
            rd_addr = src_rd.addr;
            #1 src_data = src_mem[rd_addr];
        end
    end

    task automatic fill_source();
        int r;
        int c;
        for (r = 0; r < IMG_H; r++) begin
            for (c = 0; c < IMG_W; c++) begin
                if (r < 40 && c >= 60) begin
                    src_mem[r * IMG_W + c] = FLAT_VALUE;  // Flat corner
                end else if (r >= 50 && c < 40) begin
                    src_mem[r * IMG_W + c] = ((c / 4) % 2 == 1) ? 8'hff : 8'h00;  // Stripes
                end else begin
                    src_mem[r * IMG_W + c] = 8'($urandom);
                end
            end
        end
    endtask

    task automatic apply_job(input int j);
        cfg      = jobs[j].cfg;
        job_kind = jobs[j].kind;
        n_expect = jobs[j].n_writes;
    endtask

    // Returns on the rising edge that sees done
    task automatic wait_done();
        @(negedge CLK);
        while (done !== 1'b1) @(negedge CLK);
        @(posedge CLK);
    endtask

    initial begin
        void'($urandom(SEED));
        fill_source();
        apply_job(0);
        repeat (2) @(posedge CLK);
        #1 RST = 1'b0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            wait_done();
            if (j + 1 < NUM_JOBS) begin
                #1 apply_job(j + 1);
            end
        end
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_JOBS + 1) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Forty cycles per target pixel plus 1 us
    initial begin : watchdog
        longint limit_ns;
        limit_ns = 1000;
        for (int j = 0; j < NUM_JOBS; j++) begin
            limit_ns += longint'(jobs[j].cfg.tw) * longint'(jobs[j].cfg.th) * 40 * 4;
        end
        #(limit_ns);
        $display("Timeout after %0d ns with jobs still running", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/bicubic_pkg.sv
source/cubic_weights.sv
source/interp_engine.sv
source/window_fetch.sv
source/target_stepper.sv
source/scale_sequencer.sv
source/bicubic_top.sv
verification/bicubic_checker.sv
verification/tb_bicubic.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bicubic -f tb.f -o sim_bicubic
./obj_dir/sim_bicubic | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
